/* Makefile */
VERILATOR ?= verilator
TOP       ?= fb_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/fb_defs.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/fb_defs.svh */
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// horizontal timing, in pixel clocks
`define FB_H_ACTIVE   16
`define FB_H_FRONT    2
`define FB_H_SYNC     4
`define FB_H_BACK     2
`define FB_H_TOTAL    24

// vertical timing, in lines
`define FB_V_ACTIVE   8
`define FB_V_FRONT    1
`define FB_V_SYNC     2
`define FB_V_BACK     1
`define FB_V_TOTAL    12

// external sram
`define FB_ADDR_BITS  20
`define FB_DATA_BITS  16

// position counters
`define FB_X_BITS     5
`define FB_Y_BITS     4

// timing point to vga pins
`define FB_SCAN_LAT   2

`endif

/* logic/fb_double_buf_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module fb_double_buf_top (
  input  wire                      CLK,
  input  wire                      rst_n,
  input  wire                      pix_valid,
  input  fb_pkg::pixel_t           pix_data,
  output logic                     pix_ready,
  output fb_pkg::sram_bus_t        sram0,
  input  wire  [`FB_DATA_BITS-1:0] sram0_rdata,
  output fb_pkg::sram_bus_t        sram1,
  input  wire  [`FB_DATA_BITS-1:0] sram1_rdata,
  output fb_pkg::vga_out_t         vga
);

  fb_pkg::timing_t          tim;
  logic                     swap;
  logic                     frame_done;
  logic [`FB_ADDR_BITS-1:0] wr_addr;
  logic [`FB_DATA_BITS-1:0] wr_data;
  logic                     wr_en;
  logic [`FB_ADDR_BITS-1:0] rd_addr;
  logic [`FB_DATA_BITS-1:0] rd_data;

  vga_timing vga_timing_inst (
    .CLK   (CLK),
    .rst_n (rst_n),
    .tim   (tim)
  );

  // pixel stream into the back buffer
  pixel_writer pixel_writer_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .pix_valid  (pix_valid),
    .pix_data   (pix_data),
    .pix_ready  (pix_ready),
    .swap       (swap),
    .frame_done (frame_done),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_en      (wr_en)
  );

  scanout_reader scanout_reader_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .tim     (tim),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .vga     (vga)
  );

  sram_port_mux sram_port_mux_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .frame_end   (tim.frame_end),
    .frame_done  (frame_done),
    .swap        (swap),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_en       (wr_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .sram0       (sram0),
    .sram1       (sram1),
    .sram0_rdata (sram0_rdata),
    .sram1_rdata (sram1_rdata)
  );

endmodule

`default_nettype wire

/* logic/fb_pkg.sv */
`default_nettype none

`include "fb_defs.svh"

package fb_pkg;

  // rgb444, kept in the low 12 bits of an sram word
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // one async sram, strobes active low
  typedef struct packed {
    logic [`FB_ADDR_BITS-1:0] addr;
    logic [`FB_DATA_BITS-1:0] wdata;
    logic                     we_n;
    logic                     oe_n;
    logic                     ce_n;
  } sram_bus_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;  // active low
    logic       vsync;  // active low
  } vga_out_t;

  typedef struct packed {
    logic [`FB_X_BITS-1:0] x;
    logic [`FB_Y_BITS-1:0] y;
    logic                  active;
    logic                  hsync;
    logic                  vsync;
    logic                  frame_end;  // last clock of the frame
  } timing_t;

endpackage

`default_nettype wire

/* logic/pixel_writer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module pixel_writer (
  input  wire                      CLK,
  input  wire                      rst_n,
  input  wire                      pix_valid,
  input  fb_pkg::pixel_t           pix_data,
  output logic                     pix_ready,
  input  wire                      swap,
  output logic                     frame_done,
  output logic [`FB_ADDR_BITS-1:0] wr_addr,
  output logic [`FB_DATA_BITS-1:0] wr_data,
  output logic                     wr_en
);

  localparam int PIX_BITS = $bits(fb_pkg::pixel_t);
  localparam logic [`FB_ADDR_BITS-1:0] LAST_PIX =
    `FB_ADDR_BITS'(`FB_H_ACTIVE * `FB_V_ACTIVE - 1);

  logic [`FB_ADDR_BITS-1:0] count;  // pixels taken this frame
  logic                     take;

  assign pix_ready = !frame_done;
  assign take      = pix_valid && pix_ready;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      count      <= '0;
      frame_done <= 1'b0;
      wr_en      <= 1'b0;
    end else begin
      wr_en <= take;
      if (swap) begin
        // back buffer becomes front, start filling the other one
        count      <= '0;
        frame_done <= 1'b0;
      end else if (take) begin
        count <= count + 1'b1;
        if (count == LAST_PIX) begin
          frame_done <= 1'b1;
        end
      end
    end
  end

  // write cycle one clock after the handshake
  always_ff @(posedge CLK) begin
    if (take) begin
      wr_addr <= count;
      wr_data <= {{(`FB_DATA_BITS - PIX_BITS){1'b0}}, pix_data};
    end
  end

endmodule

`default_nettype wire

/* logic/scanout_reader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module scanout_reader (
  input  wire                      CLK,
  input  wire                      rst_n,
  input  fb_pkg::timing_t          tim,
  output logic [`FB_ADDR_BITS-1:0] rd_addr,
  input  wire  [`FB_DATA_BITS-1:0] rd_data,
  output fb_pkg::vga_out_t         vga
);

  localparam int PIX_BITS = $bits(fb_pkg::pixel_t);
  localparam logic [`FB_ADDR_BITS-1:0] LINE_LEN = `FB_ADDR_BITS'(`FB_H_ACTIVE);

  typedef struct packed {
    logic active;
    logic hsync;
    logic vsync;
  } ctl_t;

  fb_pkg::pixel_t s1_pix;
  ctl_t           s1_ctl;

  // linear address into the front buffer
  always_comb begin
    if (tim.active) begin
      rd_addr = `FB_ADDR_BITS'(tim.y) * LINE_LEN + `FB_ADDR_BITS'(tim.x);
    end else begin
      rd_addr = '0;
    end
  end

  // stage 1 captures the sram word
  always_ff @(posedge CLK) begin
    s1_pix <= fb_pkg::pixel_t'(rd_data[PIX_BITS-1:0]);
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      s1_ctl.active <= 1'b0;
      s1_ctl.hsync  <= 1'b1;
      s1_ctl.vsync  <= 1'b1;
    end else begin
      s1_ctl.active <= tim.active;
      s1_ctl.hsync  <= tim.hsync;
      s1_ctl.vsync  <= tim.vsync;
    end
  end

  // stage 2 drives the pins, black outside the visible area
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      vga.red   <= '0;
      vga.green <= '0;
      vga.blue  <= '0;
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
    end else begin
      vga.red   <= s1_ctl.active ? s1_pix.red : 4'h0;
      vga.green <= s1_ctl.active ? s1_pix.green : 4'h0;
      vga.blue  <= s1_ctl.active ? s1_pix.blue : 4'h0;
      vga.hsync <= s1_ctl.hsync;
      vga.vsync <= s1_ctl.vsync;
    end
  end

endmodule

`default_nettype wire

/* logic/sram_port_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module sram_port_mux (
  input  wire                      CLK,
  input  wire                      rst_n,
  input  wire                      frame_end,
  input  wire                      frame_done,
  output logic                     swap,
  input  wire  [`FB_ADDR_BITS-1:0] wr_addr,
  input  wire  [`FB_DATA_BITS-1:0] wr_data,
  input  wire                      wr_en,
  input  wire  [`FB_ADDR_BITS-1:0] rd_addr,
  output logic [`FB_DATA_BITS-1:0] rd_data,
  output fb_pkg::sram_bus_t        sram0,
  output fb_pkg::sram_bus_t        sram1,
  input  wire  [`FB_DATA_BITS-1:0] sram0_rdata,
  input  wire  [`FB_DATA_BITS-1:0] sram1_rdata
);

  logic              front;  // 0: sram0 is displayed
  fb_pkg::sram_bus_t rd_bus;
  fb_pkg::sram_bus_t wr_bus;

  // trade buffers only on a frame boundary with a full back buffer
  assign swap = frame_end && frame_done;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      front <= 1'b0;
    end else if (swap) begin
      front <= !front;
    end
  end

  // front port reads every clock
  always_comb begin
    rd_bus.addr  = rd_addr;
    rd_bus.wdata = '0;
    rd_bus.we_n  = 1'b1;
    rd_bus.oe_n  = 1'b0;
    rd_bus.ce_n  = 1'b0;
  end

  // back port only selected while writing
  always_comb begin
    wr_bus.addr  = wr_addr;
    wr_bus.wdata = wr_data;
    wr_bus.we_n  = !wr_en;
    wr_bus.oe_n  = 1'b1;
    wr_bus.ce_n  = !wr_en;
  end

  assign sram0   = front ? wr_bus : rd_bus;
  assign sram1   = front ? rd_bus : wr_bus;
  assign rd_data = front ? sram1_rdata : sram0_rdata;

endmodule

`default_nettype wire

/* logic/vga_timing.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module vga_timing (
  input  wire             CLK,
  input  wire             rst_n,
  output fb_pkg::timing_t tim
);

  localparam logic [`FB_X_BITS-1:0] X_LAST  = `FB_X_BITS'(`FB_H_TOTAL - 1);
  localparam logic [`FB_Y_BITS-1:0] Y_LAST  = `FB_Y_BITS'(`FB_V_TOTAL - 1);
  localparam logic [`FB_X_BITS-1:0] X_VIS   = `FB_X_BITS'(`FB_H_ACTIVE);
  localparam logic [`FB_Y_BITS-1:0] Y_VIS   = `FB_Y_BITS'(`FB_V_ACTIVE);
  localparam logic [`FB_X_BITS-1:0] HS_FROM = `FB_X_BITS'(`FB_H_ACTIVE + `FB_H_FRONT);
  localparam logic [`FB_X_BITS-1:0] HS_TO   = `FB_X_BITS'(`FB_H_ACTIVE + `FB_H_FRONT
                                                          + `FB_H_SYNC);
  localparam logic [`FB_Y_BITS-1:0] VS_FROM = `FB_Y_BITS'(`FB_V_ACTIVE + `FB_V_FRONT);
  localparam logic [`FB_Y_BITS-1:0] VS_TO   = `FB_Y_BITS'(`FB_V_ACTIVE + `FB_V_FRONT
                                                          + `FB_V_SYNC);

  logic [`FB_X_BITS-1:0] x_nxt;
  logic [`FB_Y_BITS-1:0] y_nxt;

  // next position, decoded one clock early so flags line up with x/y
  always_comb begin
    x_nxt = tim.x + 1'b1;
    y_nxt = tim.y;
    if (tim.x == X_LAST) begin
      x_nxt = '0;
      if (tim.y == Y_LAST) begin
        y_nxt = '0;
      end else begin
        y_nxt = tim.y + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tim.x         <= '0;
      tim.y         <= '0;
      tim.active    <= 1'b1;  // (0,0) is visible
      tim.hsync     <= 1'b1;
      tim.vsync     <= 1'b1;
      tim.frame_end <= 1'b0;
    end else begin
      tim.x         <= x_nxt;
      tim.y         <= y_nxt;
      tim.active    <= (x_nxt < X_VIS) && (y_nxt < Y_VIS);
      tim.hsync     <= !((x_nxt >= HS_FROM) && (x_nxt < HS_TO));
      tim.vsync     <= !((y_nxt >= VS_FROM) && (y_nxt < VS_TO));
      tim.frame_end <= (x_nxt == X_LAST) && (y_nxt == Y_LAST);
    end
  end

endmodule

`default_nettype wire

/* verif/fb_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module fb_assertions (
  input wire               CLK,
  input wire               rst_n,
  input wire               pix_valid,
  input fb_pkg::pixel_t    pix_data,
  input wire               pix_ready,
  input fb_pkg::sram_bus_t sram0,
  input fb_pkg::sram_bus_t sram1,
  input fb_pkg::timing_t   tim
);

  // source must hold data while stalled
  stall_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    (pix_valid && !pix_ready) |=> $stable(pix_data))
    else $error("pix_data changed during a stalled transfer");

  no_double_write: assert property (@(posedge CLK) disable iff (!rst_n)
    !(!sram0.we_n && !sram1.we_n))
    else $error("both sram ports write strobed at once");

  // one port must be reading while the display is visible
  front_read: assert property (@(posedge CLK) disable iff (!rst_n)
    tim.active |-> ((!sram0.ce_n && !sram0.oe_n) || (!sram1.ce_n && !sram1.oe_n)))
    else $error("no sram selected for reading during active video");

endmodule

bind fb_double_buf_top fb_assertions fb_assertions_inst (
  .CLK       (CLK),
  .rst_n     (rst_n),
  .pix_valid (pix_valid),
  .pix_data  (pix_data),
  .pix_ready (pix_ready),
  .sram0     (sram0),
  .sram1     (sram1),
  .tim       (tim)
);

`default_nettype wire

/* verif/fb_sram_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module fb_sram_model (
  input  wire                      CLK,
  input  fb_pkg::sram_bus_t        bus,
  output logic [`FB_DATA_BITS-1:0] rdata
);

  localparam int DEPTH = `FB_H_ACTIVE * `FB_V_ACTIVE;

  logic [`FB_DATA_BITS-1:0] mem [0:DEPTH-1];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // async read, data only while chip and output enabled
  always_comb begin
    if (!bus.ce_n && !bus.oe_n && (bus.addr < DEPTH)) begin
      rdata = mem[bus.addr];
    end else begin
      rdata = '0;
    end
  end

  always @(posedge CLK) begin
    if (!bus.ce_n && !bus.we_n && (bus.addr < DEPTH)) begin
      mem[bus.addr] <= bus.wdata;
    end
  end

endmodule

`default_nettype wire

/* verif/fb_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fb_defs.svh"

module fb_tb;

  localparam int HALF_NS    = 4;
  localparam int H_ACT      = `FB_H_ACTIVE;
  localparam int V_ACT      = `FB_V_ACTIVE;
  localparam int H_TOT      = `FB_H_TOTAL;
  localparam int V_TOT      = `FB_V_TOTAL;
  localparam int HS_FROM    = `FB_H_ACTIVE + `FB_H_FRONT;
  localparam int HS_TO      = HS_FROM + `FB_H_SYNC;
  localparam int VS_FROM    = `FB_V_ACTIVE + `FB_V_FRONT;
  localparam int VS_TO      = VS_FROM + `FB_V_SYNC;
  localparam int NPIX       = H_ACT * V_ACT;
  localparam int FRAME_CLKS = H_TOT * V_TOT;
  localparam int RUN_FRAMES = 5;
  localparam int WATCHDOG_NS = (RUN_FRAMES + 1) * FRAME_CLKS * 2 * HALF_NS + 400;

  localparam int T_RESET   = 0;
  localparam int T_SYNC    = 1;
  localparam int T_BLACK   = 2;
  localparam int T_READY   = 3;
  localparam int T_CONTENT = 4;
  localparam int T_BACK    = 5;

  localparam fb_pkg::vga_out_t IDLE = '{red: 4'h0, green: 4'h0, blue: 4'h0,
                                         hsync: 1'b1, vsync: 1'b1};

  logic                     CLK;
  logic                     rst_n;
  logic                     pix_valid;
  fb_pkg::pixel_t           pix_data;
  logic                     pix_ready;
  fb_pkg::sram_bus_t        sram0;
  fb_pkg::sram_bus_t        sram1;
  logic [`FB_DATA_BITS-1:0] sram0_rdata;
  logic [`FB_DATA_BITS-1:0] sram1_rdata;
  fb_pkg::vga_out_t         vga;

  integer seed;

  // reference model state as of the latest rising edge
  fb_pkg::pixel_t   buf_model [0:1][0:NPIX-1];
  bit               front_m;
  int               count_m;
  bit               done_m;
  int               px;
  int               py;
  fb_pkg::vga_out_t pipe1;
  fb_pkg::vga_out_t pipe2;
  int               frame_cnt;
  int               swaps;
  bit               seen_reset;
  int               hs_low;
  int               vs_low;

  int errs [0:5];
  int compares;
  bit ended;

  fb_double_buf_top fb_double_buf_top_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .pix_valid   (pix_valid),
    .pix_data    (pix_data),
    .pix_ready   (pix_ready),
    .sram0       (sram0),
    .sram0_rdata (sram0_rdata),
    .sram1       (sram1),
    .sram1_rdata (sram1_rdata),
    .vga         (vga)
  );

  fb_sram_model sram0_model (.CLK(CLK), .bus(sram0), .rdata(sram0_rdata));
  fb_sram_model sram1_model (.CLK(CLK), .bus(sram1), .rdata(sram1_rdata));

  always #(HALF_NS) CLK = ~CLK;

  task automatic check_vga(input int t, input string name,
                           input fb_pkg::vga_out_t exp, input fb_pkg::vga_out_t act);
    compares++;
    if (act !== exp) begin
      errs[t]++;
      $display("FAIL %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_ready(input int t, input string name, input bit exp, input logic act);
    compares++;
    if (act !== exp) begin
      errs[t]++;
      $display("FAIL %s expected %b actual %b at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_count(input int t, input string name, input int exp, input int act);
    compares++;
    if (act != exp) begin
      errs[t]++;
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic report_fault(input int t, input string msg);
    errs[t]++;
    $display("error: %s at %0t", msg, $time);
  endtask

  task automatic finish_test(input int t, input string name);
    $display("test %s: %s, %0d errors", name, (errs[t] == 0) ? "ok" : "wrong", errs[t]);
  endtask

  // random valid gaps with data held while stalled
  always @(posedge CLK) begin
    logic [31:0] r;
    if (!rst_n) begin
      pix_valid <= 1'b0;
    end else if (!pix_valid || pix_ready) begin
      r = $random(seed);
      pix_valid <= (r[1:0] != 2'b00);
      r = $random(seed);
      pix_data <= r[11:0];
    end
  end

  // compare at the falling edge and step the model to the next rising edge
  always @(negedge CLK) begin
    fb_pkg::vga_out_t  cur;
    fb_pkg::sram_bus_t fbus;
    fb_pkg::pixel_t    pix;
    bit                take;
    bit                done_prev;
    if (seen_reset) begin
      check_vga((frame_cnt == 0) ? T_BLACK : T_CONTENT, "vga", pipe2, vga);
      check_ready(T_READY, "pix_ready", !done_m, pix_ready);
      fbus = front_m ? sram1 : sram0;
      if (!fbus.we_n) begin
        report_fault(T_BACK, "write strobe on the front sram");
      end
      if (fbus.ce_n || fbus.oe_n) begin
        report_fault(T_BACK, "front sram not enabled for reading");
      end
      if (frame_cnt == 1) begin
        hs_low += vga.hsync ? 0 : 1;
        vs_low += vga.vsync ? 0 : 1;
      end
    end
    if (!rst_n) begin
      seen_reset = 1'b1;
      front_m    = 1'b0;
      count_m    = 0;
      done_m     = 1'b0;
      px         = 0;
      py         = 0;
      pipe1      = IDLE;
      pipe2      = IDLE;
    end else begin
      pix = (px < H_ACT && py < V_ACT) ? buf_model[front_m][py * H_ACT + px] : '0;
      cur.red   = pix.red;
      cur.green = pix.green;
      cur.blue  = pix.blue;
      cur.hsync = !(px >= HS_FROM && px < HS_TO);
      cur.vsync = !(py >= VS_FROM && py < VS_TO);
      pipe2 = pipe1;
      pipe1 = cur;
      take      = pix_valid && pix_ready;
      done_prev = done_m;  // full frame must be in before this clock
      if (take && count_m < NPIX) begin
        buf_model[!front_m][count_m] = pix_data;
        count_m++;
        if (count_m == NPIX) begin
          done_m = 1'b1;
        end
      end
      if (px == H_TOT - 1 && py == V_TOT - 1) begin
        frame_cnt++;
        if (done_prev) begin  // swap at frame end
          front_m = !front_m;
          count_m = 0;
          done_m  = 1'b0;
          swaps++;
        end
      end
      if (px == H_TOT - 1) begin
        px = 0;
        py = (py == V_TOT - 1) ? 0 : py + 1;
      end else begin
        px++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("CHECKS FAILED");
    ended = 1'b1;
    $finish;
  end

  initial begin
    int total;
    CLK       = 1'b0;
    rst_n     = 1'b0;
    pix_valid = 1'b0;
    pix_data  = '0;
    seed      = 32'hd570_4e20;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < NPIX; i++) begin
        buf_model[b][i] = '0;
      end
    end
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;

    @(negedge CLK);
    check_vga(T_RESET, "reset_vga", IDLE, vga);
    check_ready(T_RESET, "reset_ready", 1'b1, pix_ready);
    if (!sram0.we_n || !sram1.we_n) begin
      report_fault(T_RESET, "sram write strobe active right after reset");
    end
    finish_test(T_RESET, "reset_state");

    wait (frame_cnt >= 1);
    repeat (3) @(negedge CLK);  // last visible pixel leaves the pipeline
    finish_test(T_BLACK, "black_first_frame");

    wait (frame_cnt >= 2);
    check_count(T_SYNC, "hsync_low_clocks", 4 * V_TOT, hs_low);
    check_count(T_SYNC, "vsync_low_clocks", 2 * H_TOT, vs_low);
    finish_test(T_SYNC, "sync_timing");

    wait (frame_cnt >= RUN_FRAMES);
    @(negedge CLK);
    if (swaps < RUN_FRAMES - 2) begin
      report_fault(T_CONTENT, "buffers swapped fewer times than expected");
    end
    finish_test(T_READY, "ready_backpressure");
    finish_test(T_CONTENT, "frame_content");
    finish_test(T_BACK, "back_buffer_writes");

    total = 0;
    for (int t = 0; t < 6; t++) begin
      total += errs[t];
    end
    $display("summary: 6 tests, %0d compares, %0d swaps, %0d errors", compares, swaps, total);
    ended = 1'b1;
    if (total == 0 && compares > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  final begin
    if (!ended) begin
      $display("CHECKS FAILED");
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/fb_pkg.sv
logic/vga_timing.sv
logic/pixel_writer.sv
logic/scanout_reader.sv
logic/sram_port_mux.sv
logic/fb_double_buf_top.sv
verif/fb_sram_model.sv
verif/fb_assertions.sv
verif/fb_tb.sv
